/* logic/axi_slv_pkg.sv */
// full-width beats only; one burst at a time; 4 KiB crossings are not checked
package axi_slv_pkg;

	////////////////////////////////////////////////////////////
	// widths and depths
	////////////////////////////////////////////////////////////
	localparam int DW        = 64;
	localparam int AW        = 16;
	localparam int ID_W      = 4;
	localparam int MEM_WORDS = 256;
	localparam int ADDR_LSB  = $clog2(DW / 8);
	localparam int MEM_AW    = $clog2(MEM_WORDS);

	// burst and response codes
	localparam logic [1:0] BURST_FIXED = 2'b00;
	localparam logic [1:0] BURST_INCR  = 2'b01;
	localparam logic [1:0] BURST_WRAP  = 2'b10;
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	////////////////////////////////////////////////////////////
	// channel payloads
	////////////////////////////////////////////////////////////
	// shared by AW and AR
	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [AW-1:0]   addr;
		logic [7:0]      len;
		logic [1:0]      burst;
	} axi_addr_req_t;

	typedef struct packed {
		logic [DW-1:0]     data;
		logic [DW/8-1:0]   strb;
		logic              last;
	} axi_w_beat_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [1:0]      resp;
	} axi_b_resp_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [DW-1:0]   data;
		logic [1:0]      resp;
		logic            last;
	} axi_r_beat_t;

	// memory ports, engine to arbiter
	typedef struct packed {
		logic              en;
		logic [MEM_AW-1:0] idx;
		logic [DW-1:0]     data;
		logic [DW/8-1:0]   strb;
	} mem_wr_t;

	typedef struct packed {
		logic              en;
		logic [MEM_AW-1:0] idx;
	} mem_rd_t;

endpackage

/* logic/axi_burst_addr.sv */
// WRAP is honoured for 2, 4, 8 or 16 beats only; other WRAP lengths step as INCR
`timescale 1ns/100ps

module axi_burst_addr import axi_slv_pkg::*; (
	input  logic [AW-1:0] addr,
	input  logic [7:0]    len,
	input  logic [1:0]    burst,
	output logic [AW-1:0] next_addr,
	output logic          out_of_range
);

	logic [AW-1:0] incr_addr;
	logic [AW-1:0] wrap_mask;
	logic          wrap_ok;

	// one full beat ahead
	assign incr_addr = addr + AW'(1 << ADDR_LSB);

	// legal wrap lengths
	assign wrap_ok = (len == 8'd1) || (len == 8'd3) || (len == 8'd7) || (len == 8'd15);

	// window size in bytes minus one
	assign wrap_mask = AW'({len, {ADDR_LSB{1'b1}}});

	always_comb begin
		case (burst)
			BURST_FIXED: begin
				next_addr = addr;
			end
			BURST_WRAP: begin
				if (wrap_ok) begin
					next_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);
				end else begin
					next_addr = incr_addr;
				end
			end
			default: begin
				// INCR and the reserved code
				next_addr = incr_addr;
			end
		endcase
	end

	// word index beyond the memory
	assign out_of_range = (addr >> ADDR_LSB) >= AW'(MEM_WORDS);

endmodule

/* logic/axi_wr_engine.sv */
// one write burst at a time; wlast ends the burst, awlen only shapes WRAP addressing
`timescale 1ns/100ps

module axi_wr_engine import axi_slv_pkg::*; (
	input  logic          CLK,
	input  logic          rst,
	input  axi_addr_req_t aw,
	input  logic          aw_valid,
	output logic          aw_ready,
	input  axi_w_beat_t   w,
	input  logic          w_valid,
	output logic          w_ready,
	output axi_b_resp_t   b,
	output logic          b_valid,
	input  logic          b_ready,
	output logic          wr_req,
	input  logic          wr_gnt,
	output mem_wr_t       mem_wr
);

	typedef enum logic [2:0] {
		st_idle,
		st_wait_gnt,
		st_addr,
		st_data,
		st_resp
	} wr_state_t;

	wr_state_t       state;
	logic [ID_W-1:0] id_q;
	logic [AW-1:0]   addr_q;
	logic [7:0]      len_q;
	logic [1:0]      burst_q;
	logic [1:0]      resp_q;
	logic [AW-1:0]   next_addr;
	logic            oor;
	logic            w_hs;

	axi_burst_addr u_step (
		.addr         (addr_q),
		.len          (len_q),
		.burst        (burst_q),
		.next_addr    (next_addr),
		.out_of_range (oor)
	);

	assign wr_req   = (state != st_idle);
	assign aw_ready = (state == st_addr);
	assign w_ready  = (state == st_data);
	assign b_valid  = (state == st_resp);
	assign w_hs     = w_ready & w_valid;

	assign b.id   = id_q;
	assign b.resp = resp_q;

	// out of range beats never reach the memory
	assign mem_wr.en   = w_hs & ~oor;
	assign mem_wr.idx  = addr_q[ADDR_LSB +: MEM_AW];
	assign mem_wr.data = w.data;
	assign mem_wr.strb = w.strb;

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:     if (aw_valid) state <= st_wait_gnt;
				st_wait_gnt: if (wr_gnt) state <= st_addr;
				st_addr:     if (aw_valid) state <= st_data;
				st_data:     if (w_hs && w.last) state <= st_resp;
				st_resp:     if (b_ready) state <= st_idle;
				default:     state <= st_idle;
			endcase
		end
	end

	// burst context and sticky response
	always_ff @(posedge CLK) begin
		if (aw_ready && aw_valid) begin
			id_q    <= aw.id;
			addr_q  <= aw.addr;
			len_q   <= aw.len;
			burst_q <= aw.burst;
			resp_q  <= RESP_OKAY;
		end else if (w_hs) begin
			addr_q <= next_addr;
			if (oor) begin
				resp_q <= RESP_SLVERR;
			end
		end
	end

endmodule

/* logic/axi_rd_engine.sv */
// one read burst at a time; a beat every two cycles at best
`timescale 1ns/100ps

module axi_rd_engine import axi_slv_pkg::*; (
	input  logic          CLK,
	input  logic          rst,
	input  axi_addr_req_t ar,
	input  logic          ar_valid,
	output logic          ar_ready,
	output axi_r_beat_t   r,
	output logic          r_valid,
	input  logic          r_ready,
	output logic          rd_req,
	input  logic          rd_gnt,
	input  logic [DW-1:0] rd_data,
	output mem_rd_t       mem_rd
);

	typedef enum logic [2:0] {
		st_idle,
		st_wait_gnt,
		st_addr,
		st_fetch,
		st_beat
	} rd_state_t;

	rd_state_t       state;
	logic [ID_W-1:0] id_q;
	logic [AW-1:0]   addr_q;
	logic [7:0]      len_q;
	logic [1:0]      burst_q;
	logic [7:0]      cnt_q;
	logic [AW-1:0]   next_addr;
	logic            oor;
	logic            r_hs;

	axi_burst_addr u_step (
		.addr         (addr_q),
		.len          (len_q),
		.burst        (burst_q),
		.next_addr    (next_addr),
		.out_of_range (oor)
	);

	assign rd_req   = (state != st_idle);
	assign ar_ready = (state == st_addr);
	assign r_valid  = (state == st_beat);
	assign r_hs     = r_valid & r_ready;

	assign mem_rd.en  = (state == st_fetch) & ~oor;
	assign mem_rd.idx = addr_q[ADDR_LSB +: MEM_AW];

	// address holds during the beat, so oor still belongs to it
	assign r.id   = id_q;
	assign r.data = oor ? '0 : rd_data;
	assign r.resp = oor ? RESP_SLVERR : RESP_OKAY;
	assign r.last = (cnt_q == len_q);

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:     if (ar_valid) state <= st_wait_gnt;
				st_wait_gnt: if (rd_gnt) state <= st_addr;
				st_addr:     if (ar_valid) state <= st_fetch;
				st_fetch:    state <= st_beat;
				st_beat: begin
					if (r_ready) begin
						state <= r.last ? st_idle : st_fetch;
					end
				end
				default:     state <= st_idle;
			endcase
		end
	end

	// burst context and beat count
	always_ff @(posedge CLK) begin
		if (ar_ready && ar_valid) begin
			id_q    <= ar.id;
			addr_q  <= ar.addr;
			len_q   <= ar.len;
			burst_q <= ar.burst;
			cnt_q   <= 8'd0;
		end else if (r_hs) begin
			addr_q <= next_addr;
			cnt_q  <= cnt_q + 8'd1;
		end
	end

endmodule

/* logic/axi_mem_arb.sv */
// single-port memory with per-burst grants; write wins a tie from idle
`timescale 1ns/100ps

module axi_mem_arb import axi_slv_pkg::*; (
	input  logic          CLK,
	input  logic          rst,
	input  logic          wr_req,
	input  logic          rd_req,
	output logic          wr_gnt,
	output logic          rd_gnt,
	input  mem_wr_t       mem_wr,
	input  mem_rd_t       mem_rd,
	output logic [DW-1:0] rd_data
);

	logic [DW-1:0] mem [MEM_WORDS];

	////////////////////////////////////////////////////////////
	// grant, held for the whole burst
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_gnt <= 1'b0;
			rd_gnt <= 1'b0;
		end else if (wr_gnt) begin
			if (!wr_req) begin
				wr_gnt <= 1'b0;
			end
		end else if (rd_gnt) begin
			if (!rd_req) begin
				rd_gnt <= 1'b0;
			end
		end else if (wr_req) begin
			wr_gnt <= 1'b1;
		end else if (rd_req) begin
			rd_gnt <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	// only the granted engine reaches the array
	always_ff @(posedge CLK) begin
		if (wr_gnt && mem_wr.en) begin
			for (int i = 0; i < DW / 8; i++) begin
				if (mem_wr.strb[i]) begin
					mem[mem_wr.idx][i*8 +: 8] <= mem_wr.data[i*8 +: 8];
				end
			end
		end
	end

	// read word holds until the next read enable
	always_ff @(posedge CLK) begin
		if (rd_gnt && mem_rd.en) begin
			rd_data <= mem[mem_rd.idx];
		end
	end

endmodule

/* logic/axi_full_slv.sv */
// AXI4 slave over 2 KiB; no narrow transfers, no exclusives, one burst in flight
`timescale 1ns/100ps

module axi_full_slv import axi_slv_pkg::*; (
	input  logic          CLK,
	input  logic          rst,
	input  axi_addr_req_t s_aw,
	input  logic          s_aw_valid,
	output logic          s_aw_ready,
	input  axi_w_beat_t   s_w,
	input  logic          s_w_valid,
	output logic          s_w_ready,
	output axi_b_resp_t   s_b,
	output logic          s_b_valid,
	input  logic          s_b_ready,
	input  axi_addr_req_t s_ar,
	input  logic          s_ar_valid,
	output logic          s_ar_ready,
	output axi_r_beat_t   s_r,
	output logic          s_r_valid,
	input  logic          s_r_ready
);

	logic          wr_req;
	logic          wr_gnt;
	logic          rd_req;
	logic          rd_gnt;
	mem_wr_t       mem_wr;
	mem_rd_t       mem_rd;
	logic [DW-1:0] rd_data;

	axi_wr_engine u_wr (
		.CLK (CLK), .rst (rst),
		.aw (s_aw), .aw_valid (s_aw_valid), .aw_ready (s_aw_ready),
		.w (s_w), .w_valid (s_w_valid), .w_ready (s_w_ready),
		.b (s_b), .b_valid (s_b_valid), .b_ready (s_b_ready),
		.wr_req (wr_req), .wr_gnt (wr_gnt), .mem_wr (mem_wr)
	);

	axi_rd_engine u_rd (
		.CLK (CLK), .rst (rst),
		.ar (s_ar), .ar_valid (s_ar_valid), .ar_ready (s_ar_ready),
		.r (s_r), .r_valid (s_r_valid), .r_ready (s_r_ready),
		.rd_req (rd_req), .rd_gnt (rd_gnt), .rd_data (rd_data), .mem_rd (mem_rd)
	);

	// the one meeting point of both engines
	axi_mem_arb u_arb (
		.CLK (CLK), .rst (rst),
		.wr_req (wr_req), .rd_req (rd_req), .wr_gnt (wr_gnt), .rd_gnt (rd_gnt),
		.mem_wr (mem_wr), .mem_rd (mem_rd), .rd_data (rd_data)
	);

endmodule

/* tests/axi_full_slv_props.sv */
// slave-side handshake rules only; assumes the master holds its own valids until accepted
`timescale 1ns/100ps

module axi_full_slv_props import axi_slv_pkg::*; (
	input logic        CLK,
	input logic        rst,
	input logic        s_aw_ready,
	input logic        s_w_ready,
	input axi_b_resp_t s_b,
	input logic        s_b_valid,
	input logic        s_b_ready,
	input logic        s_ar_ready,
	input axi_r_beat_t s_r,
	input logic        s_r_valid,
	input logic        s_r_ready
);

	int fail_cnt = 0;

	// responses wait for the master
	b_valid_hold: assert property (@(posedge CLK) disable iff (rst)
		s_b_valid && !s_b_ready |=> s_b_valid && $stable(s_b))
	else begin
		$error("bvalid dropped or B payload changed while stalled");
		fail_cnt++;
	end

	r_valid_hold: assert property (@(posedge CLK) disable iff (rst)
		s_r_valid && !s_r_ready |=> s_r_valid && $stable(s_r))
	else begin
		$error("rvalid dropped or R payload changed while stalled");
		fail_cnt++;
	end

	// one engine owns the memory until its B or last R handshake
	no_wr_rd_overlap: assert property (@(posedge CLK) disable iff (rst)
		!((s_w_ready || s_b_valid) && (s_ar_ready || s_r_valid)))
	else begin
		$error("a write data or response phase overlapped a read phase");
		fail_cnt++;
	end

	reset_quiet: assert property (@(posedge CLK)
		rst && $past(rst) |-> !(s_aw_ready || s_w_ready || s_b_valid || s_ar_ready || s_r_valid))
	else begin
		$error("ready or valid high during reset");
		fail_cnt++;
	end

endmodule

bind axi_full_slv axi_full_slv_props u_props (
	.CLK (CLK), .rst (rst),
	.s_aw_ready (s_aw_ready), .s_w_ready (s_w_ready),
	.s_b (s_b), .s_b_valid (s_b_valid), .s_b_ready (s_b_ready),
	.s_ar_ready (s_ar_ready),
	.s_r (s_r), .s_r_valid (s_r_valid), .s_r_ready (s_r_ready)
);

/* tests/tb_axi_full_slv.sv */
// bursts run one after another except one write/read overlap; reference memory assumes full-width beats
`timescale 1ns/100ps

module tb_axi_full_slv import axi_slv_pkg::*; ();

	localparam int NUM_TESTS = 5;

	logic          CLK;
	logic          rst;
	axi_addr_req_t aw;
	logic          aw_valid;
	logic          aw_ready;
	axi_w_beat_t   w;
	logic          w_valid;
	logic          w_ready;
	axi_b_resp_t   b;
	logic          b_valid;
	logic          b_ready;
	axi_addr_req_t ar;
	logic          ar_valid;
	logic          ar_ready;
	axi_r_beat_t   r;
	logic          r_valid;
	logic          r_ready;

	logic [DW-1:0] ref_mem [MEM_WORDS];
	logic [31:0]   seed = 32'd43452;
	int            errors = 0;

	axi_full_slv UUT (
		.CLK (CLK), .rst (rst),
		.s_aw (aw), .s_aw_valid (aw_valid), .s_aw_ready (aw_ready),
		.s_w (w), .s_w_valid (w_valid), .s_w_ready (w_ready),
		.s_b (b), .s_b_valid (b_valid), .s_b_ready (b_ready),
		.s_ar (ar), .s_ar_valid (ar_valid), .s_ar_ready (ar_ready),
		.s_r (r), .s_r_valid (r_valid), .s_r_ready (r_ready)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	initial begin
		#(NUM_TESTS * 3000);
		$display("timeout: the slave stopped answering a handshake");
		$display("Test FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// ready about two cycles in three
	function automatic logic ready_draw();
		return ((next_rand() >> 16) % 3) != 0;
	endfunction

	function automatic logic in_range(logic [AW-1:0] addr);
		return addr < AW'(MEM_WORDS * (DW / 8));
	endfunction

	function automatic logic [AW-1:0] beat_addr_after(logic [AW-1:0] addr, logic [7:0] len,
			logic [1:0] burst);
		int bytes;
		int base;
		bytes = (int'(len) + 1) * (DW / 8);
		if (burst == BURST_FIXED) begin
			return addr;
		end
		if (burst == BURST_WRAP && (len == 8'd1 || len == 8'd3 || len == 8'd7 || len == 8'd15)) begin
			base = int'(addr) - (int'(addr) % bytes);
			return AW'(base + ((int'(addr) - base + DW / 8) % bytes));
		end
		return addr + AW'(DW / 8);
	endfunction

	task automatic check_value(string name, string what, logic [DW-1:0] exp, logic [DW-1:0] act);
		assert (act == exp) else begin
			$display("ERR %s %s: expected %h actual %h", name, what, exp, act);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// bursts
	////////////////////////////////////////////////////////////
	task automatic write_burst(string name, logic [ID_W-1:0] id, logic [AW-1:0] addr,
			logic [7:0] len, logic [1:0] burst);
		logic [AW-1:0] cur;
		logic [1:0]    exp_resp;
		cur = addr;
		exp_resp = RESP_OKAY;
		@(negedge CLK);
		aw = '{id: id, addr: addr, len: len, burst: burst};
		aw_valid = 1'b1;
		while (!aw_ready) @(negedge CLK);
		@(negedge CLK);
		aw_valid = 1'b0;
		for (int i = 0; i <= int'(len); i++) begin
			w.data = {next_rand(), next_rand()};
			w.strb = 8'(next_rand() >> 8);
			w.last = (i == int'(len));
			w_valid = 1'b1;
			while (!w_ready) @(negedge CLK);
			if (in_range(cur)) begin
				for (int k = 0; k < DW / 8; k++) begin
					if (w.strb[k]) begin
						ref_mem[cur[ADDR_LSB +: MEM_AW]][k*8 +: 8] = w.data[k*8 +: 8];
					end
				end
			end else begin
				exp_resp = RESP_SLVERR;
			end
			cur = beat_addr_after(cur, len, burst);
			@(negedge CLK);
		end
		w_valid = 1'b0;
		b_ready = ready_draw();
		while (!(b_valid && b_ready)) begin
			@(negedge CLK);
			b_ready = ready_draw();
		end
		check_value(name, "bid", DW'(id), DW'(b.id));
		check_value(name, "bresp", DW'(exp_resp), DW'(b.resp));
		@(negedge CLK);
		b_ready = 1'b0;
	endtask

	task automatic read_burst(string name, logic [ID_W-1:0] id, logic [AW-1:0] addr,
			logic [7:0] len, logic [1:0] burst);
		logic [AW-1:0] cur;
		logic [DW-1:0] exp_data;
		cur = addr;
		@(negedge CLK);
		ar = '{id: id, addr: addr, len: len, burst: burst};
		ar_valid = 1'b1;
		while (!ar_ready) @(negedge CLK);
		@(negedge CLK);
		ar_valid = 1'b0;
		for (int i = 0; i <= int'(len); i++) begin
			r_ready = ready_draw();
			while (!(r_valid && r_ready)) begin
				@(negedge CLK);
				r_ready = ready_draw();
			end
			exp_data = in_range(cur) ? ref_mem[cur[ADDR_LSB +: MEM_AW]] : '0;
			check_value(name, "rid", DW'(id), DW'(r.id));
			check_value(name, "rdata", exp_data, r.data);
			check_value(name, "rresp", DW'(in_range(cur) ? RESP_OKAY : RESP_SLVERR), DW'(r.resp));
			check_value(name, "rlast", DW'(i == int'(len)), DW'(r.last));
			cur = beat_addr_after(cur, len, burst);
			@(negedge CLK);
		end
		r_ready = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// sequence
	////////////////////////////////////////////////////////////
	initial begin
		int         prop_fails;
		logic [7:0] incr_len;
		rst = 1'b1;
		aw = '0;
		aw_valid = 1'b0;
		w = '0;
		w_valid = 1'b0;
		b_ready = 1'b0;
		ar = '0;
		ar_valid = 1'b0;
		r_ready = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = '0;
		end
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;

		incr_len = 8'(next_rand() % 32);
		write_burst("incr", 4'h1, 16'h0040, incr_len, BURST_INCR);
		read_burst("incr", 4'h2, 16'h0040, incr_len, BURST_INCR);
		write_burst("fixed", 4'h3, 16'h0300, 8'd3, BURST_FIXED);
		read_burst("fixed", 4'h4, 16'h0300, 8'd3, BURST_FIXED);
		// both wraps start mid window
		write_burst("wrap4", 4'h5, 16'h0410, 8'd3, BURST_WRAP);
		read_burst("wrap4", 4'h6, 16'h0410, 8'd3, BURST_WRAP);
		write_burst("wrap8", 4'h7, 16'h0528, 8'd7, BURST_WRAP);
		read_burst("wrap8", 4'h8, 16'h0528, 8'd7, BURST_WRAP);
		// last four beats fall past 0x07ff
		write_burst("oor", 4'h9, 16'h07E0, 8'd7, BURST_INCR);
		read_burst("oor", 4'hA, 16'h07E0, 8'd7, BURST_INCR);
		// AR lands while the W beats are still flowing
		fork
			write_burst("overlap", 4'hB, 16'h0600, 8'd15, BURST_INCR);
			begin
				repeat (4) @(negedge CLK);
				read_burst("overlap", 4'hC, 16'h0600, 8'd15, BURST_INCR);
			end
		join
		repeat (4) @(negedge CLK);

		prop_fails = UUT.u_props.fail_cnt;
		$display("errors: %0d data, %0d protocol", errors, prop_fails);
		if (errors == 0 && prop_fails == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
logic/axi_slv_pkg.sv
logic/axi_burst_addr.sv
logic/axi_wr_engine.sv
logic/axi_rd_engine.sv
logic/axi_mem_arb.sv
logic/axi_full_slv.sv
tests/axi_full_slv_props.sv
tests/tb_axi_full_slv.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_axi_full_slv
FILELIST := project.f
OBJ_DIR  := obj_dir
RUN_ARGS := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
